/* design/cachePkg.sv */
`default_nettype none

package cachePkg;

  localparam int WORD_W = 32;
  localparam int BOFF_W = 2;       // byte offset bits

  // data cache geometry
  localparam int DFRAMES   = 16;
  localparam int D_BLK_BIT = 2;
  localparam int D_IDX_LSB = 3;
  localparam int D_IDX_MSB = 6;
  localparam int D_TAG_LSB = 7;
  localparam int D_IDX_W   = D_IDX_MSB - D_IDX_LSB + 1;
  localparam int D_TAG_W   = WORD_W - D_TAG_LSB;
  localparam int FLCT_W    = 5;    // must reach DFRAMES

  // instruction cache geometry
  localparam int IFRAMES   = 16;
  localparam int I_IDX_LSB = 2;
  localparam int I_IDX_MSB = 5;
  localparam int I_TAG_LSB = 6;
  localparam int I_IDX_W   = I_IDX_MSB - I_IDX_LSB + 1;
  localparam int I_TAG_W   = WORD_W - I_TAG_LSB;

  typedef enum logic [3:0] {
    IDLE, WB1, WB2, READ1, READ2,
    FLSTART, FLUSH1, FLUSH2, FLCT, HALT
  } dState;

  typedef enum logic {
    OWN_D, OWN_I
  } busOwner;

endpackage

`default_nettype wire

/* design/cacheSystem.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheSystem (
  input  logic CLK, nRST,
  // data side
  input  logic dmemREN, dmemWEN, flush,
  input  logic [cachePkg::WORD_W-1:0] dmemAddr, dmemStore,
  output logic dhit, halt,
  output logic [cachePkg::WORD_W-1:0] dmemLoad,
  // instruction side
  input  logic imemREN,
  input  logic [cachePkg::WORD_W-1:0] imemAddr,
  output logic ihit,
  output logic [cachePkg::WORD_W-1:0] imemLoad,
  // memory bus
  input  logic ramWait,
  input  logic [cachePkg::WORD_W-1:0] ramLoad,
  output logic ramREN, ramWEN,
  output logic [cachePkg::WORD_W-1:0] ramAddr, ramStore
);
  import cachePkg::*;

  logic dREN, dWEN, dwait, iREN, iwait;
  logic dirty, blof, fillEn, wbClr, flctup, flushing, flctDone;
  logic [WORD_W-1:0] dAddr, dStore, dLoad, iAddr, iLoad;

  dcacheCtrl u_dctrl (
    .CLK, .nRST, .dirty, .dhit, .dwait, .dmemREN, .dmemWEN, .flush,
    .flctDone, .dREN, .dWEN, .blof, .fillEn, .wbClr, .flctup,
    .flushing, .halt
  );

  dcacheData u_ddata (
    .CLK, .nRST, .dmemREN, .dmemWEN, .flushing, .blof, .fillEn, .wbClr,
    .flctup, .dmemAddr, .dmemStore, .dLoad, .dhit, .dirty, .flctDone,
    .dmemLoad, .dAddr, .dStore
  );

  icache u_icache (
    .CLK, .nRST, .imemREN, .imemAddr, .iLoad, .iwait,
    .ihit, .iREN, .imemLoad, .iAddr
  );

  memArbiter u_arb (
    .CLK, .nRST, .dREN, .dWEN, .iREN, .ramWait, .dAddr, .dStore, .iAddr,
    .ramLoad, .dwait, .iwait, .ramREN, .ramWEN, .dLoad, .iLoad,
    .ramAddr, .ramStore
  );

endmodule

`default_nettype wire

/* design/dcacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheCtrl (
  input  logic CLK, nRST,
  input  logic dirty,
  input  logic dhit, dwait,
  input  logic dmemREN, dmemWEN, flush,   // from datapath
  input  logic flctDone,
  output logic dREN, dWEN,                // to arbiter
  output logic blof,
  output logic fillEn,
  output logic wbClr,
  output logic flctup,
  output logic flushing, halt
);
  import cachePkg::*;

  dState state, nxtState;
  logic miss;

  assign miss = (dmemREN | dmemWEN) & ~dhit;

  always_comb begin
    dREN     = 1'b0;
    dWEN     = 1'b0;
    blof     = 1'b0;
    fillEn   = 1'b0;
    wbClr    = 1'b0;
    flctup   = 1'b0;
    flushing = 1'b0;
    halt     = 1'b0;
    case (state)
      WB1: dWEN = 1'b1;
      WB2: begin
        dWEN  = 1'b1;
        blof  = 1'b1;
        wbClr = ~dwait;     // block gone after last word
      end
      READ1: begin
        dREN   = 1'b1;
        fillEn = ~dwait;
      end
      READ2: begin
        dREN   = 1'b1;
        blof   = 1'b1;
        fillEn = ~dwait;
      end
      FLSTART: flushing = 1'b1;
      FLUSH1: begin
        flushing = 1'b1;
        dWEN     = 1'b1;
      end
      FLUSH2: begin
        flushing = 1'b1;
        dWEN     = 1'b1;
        blof     = 1'b1;
        wbClr    = ~dwait;
      end
      FLCT: begin
        flushing = 1'b1;
        flctup   = 1'b1;
      end
      HALT: halt = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    case (state)
      IDLE: begin
        if (miss)
          nxtState = dirty ? WB1 : READ1;
        else if (flush)
          nxtState = FLSTART;
        else
          nxtState = IDLE;
      end
      WB1:     nxtState = ~dwait ? WB2 : WB1;
      WB2:     nxtState = ~dwait ? READ1 : WB2;
      READ1:   nxtState = ~dwait ? READ2 : READ1;
      READ2:   nxtState = ~dwait ? IDLE : READ2;
      // counter reaching the end wins over the frame state
      FLSTART: nxtState = flctDone ? HALT : (dirty ? FLUSH1 : FLCT);
      FLUSH1:  nxtState = ~dwait ? FLUSH2 : FLUSH1;
      FLUSH2:  nxtState = ~dwait ? FLCT : FLUSH2;
      FLCT:    nxtState = FLSTART;
      HALT:    nxtState = HALT;   // until reset
      default: nxtState = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      state <= IDLE;
    else
      state <= nxtState;
  end

endmodule

`default_nettype wire

/* design/dcacheData.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheData (
  input  logic CLK, nRST,
  input  logic dmemREN, dmemWEN,
  input  logic flushing,
  input  logic blof,
  input  logic fillEn,
  input  logic wbClr,
  input  logic flctup,
  input  logic [cachePkg::WORD_W-1:0] dmemAddr, dmemStore, dLoad,
  output logic dhit, dirty, flctDone,
  output logic [cachePkg::WORD_W-1:0] dmemLoad, dAddr, dStore
);
  import cachePkg::*;

  logic [WORD_W-1:0]  dataArr [DFRAMES][2];
  logic [D_TAG_W-1:0] tagArr [DFRAMES];
  logic [DFRAMES-1:0] validArr, dirtyArr;

  logic [FLCT_W-1:0]  flct;
  logic [D_IDX_W-1:0] idx;
  logic [D_TAG_W-1:0] reqTag;
  logic [WORD_W-1:0]  victimAddr, fillAddr;
  logic               storeHit;
  logic               frameDirty;

  // flush walk owns the index
  assign idx    = flushing ? flct[D_IDX_W-1:0] : dmemAddr[D_IDX_MSB:D_IDX_LSB];
  assign reqTag = dmemAddr[WORD_W-1:D_TAG_LSB];

  assign dhit = (dmemREN | dmemWEN) & ~flushing & validArr[idx]
              & (tagArr[idx] == reqTag);
  assign storeHit = dmemWEN & dhit;

  assign frameDirty = validArr[idx] & dirtyArr[idx];
  assign dirty      = frameDirty;

  assign flctDone = (flct == FLCT_W'(DFRAMES));

  assign dmemLoad = dataArr[idx][dmemAddr[D_BLK_BIT]];

  assign victimAddr = {tagArr[idx], idx, blof, {BOFF_W{1'b0}}};
  assign fillAddr   = {dmemAddr[WORD_W-1:D_BLK_BIT+1], blof, {BOFF_W{1'b0}}};

  // dirty frame means we are still writing it back
  assign dAddr  = (flushing | frameDirty) ? victimAddr : fillAddr;
  assign dStore = dataArr[idx][blof];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      validArr <= '0;
      dirtyArr <= '0;
      flct     <= '0;
    end else begin
      if (wbClr) begin
        validArr[idx] <= 1'b0;
        dirtyArr[idx] <= 1'b0;
      end else if (fillEn && blof) begin
        validArr[idx] <= 1'b1;   // block complete
        dirtyArr[idx] <= 1'b0;
      end else if (storeHit) begin
        dirtyArr[idx] <= 1'b1;
      end
      if (flctup)
        flct <= flct + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (fillEn) begin
      dataArr[idx][blof] <= dLoad;
      // tag only on the last word, else word 1 could hit stale
      if (blof)
        tagArr[idx] <= reqTag;
    end else if (storeHit) begin
      dataArr[idx][dmemAddr[D_BLK_BIT]] <= dmemStore;
    end
  end

endmodule

`default_nettype wire

/* design/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic CLK, nRST, imemREN,
  input  logic [cachePkg::WORD_W-1:0] imemAddr, iLoad,
  input  logic iwait,
  output logic ihit, iREN,
  output logic [cachePkg::WORD_W-1:0] imemLoad, iAddr
);
  import cachePkg::*;

  logic [WORD_W-1:0]  dataArr [IFRAMES];
  logic [I_TAG_W-1:0] tagArr [IFRAMES];
  logic [IFRAMES-1:0] validArr;

  logic [I_IDX_W-1:0] idx;
  logic [I_TAG_W-1:0] reqTag;
  logic               fill;

  assign idx    = imemAddr[I_IDX_MSB:I_IDX_LSB];
  assign reqTag = imemAddr[WORD_W-1:I_TAG_LSB];

  assign ihit     = imemREN & validArr[idx] & (tagArr[idx] == reqTag);
  assign imemLoad = dataArr[idx];

  // miss holds the bus request until the word comes back
  assign iREN  = imemREN & ~ihit;
  assign iAddr = {imemAddr[WORD_W-1:BOFF_W], {BOFF_W{1'b0}}};
  assign fill  = iREN & ~iwait;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      validArr <= '0;
    else if (fill)
      validArr[idx] <= 1'b1;
  end

  always_ff @(posedge CLK) begin
    if (fill) begin
      dataArr[idx] <= iLoad;
      tagArr[idx]  <= reqTag;
    end
  end

endmodule

`default_nettype wire

/* design/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
  input  logic CLK, nRST,
  input  logic dREN, dWEN, iREN,
  input  logic ramWait,
  input  logic [cachePkg::WORD_W-1:0] dAddr, dStore, iAddr, ramLoad,
  output logic dwait, iwait,
  output logic ramREN, ramWEN,
  output logic [cachePkg::WORD_W-1:0] dLoad, iLoad, ramAddr, ramStore
);
  import cachePkg::*;

  busOwner owner, grant;
  logic    busy;
  logic    dReq, grantReq;

  assign dReq = dREN | dWEN;

  always_comb begin
    if (busy)
      grant = owner;               // hold while owner still asks
    else
      grant = dReq ? OWN_D : OWN_I;  // data side first
    grantReq = (grant == OWN_D) ? dReq : iREN;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      owner <= OWN_D;
      busy  <= 1'b0;
    end else begin
      owner <= grant;
      busy  <= grantReq;
    end
  end

  assign ramREN   = (grant == OWN_D) ? dREN : iREN;
  assign ramWEN   = (grant == OWN_D) ? dWEN : 1'b0;   // icache is read only
  assign ramAddr  = (grant == OWN_D) ? dAddr : iAddr;
  assign ramStore = dStore;

  // loser keeps waiting
  assign dwait = (grant == OWN_D) ? ramWait : 1'b1;
  assign iwait = (grant == OWN_I) ? ramWait : 1'b1;

  assign dLoad = ramLoad;
  assign iLoad = ramLoad;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_cacheSystem -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* testbench/cacheMonitor.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheMonitor (
  input  logic CLK, nRST,
  input  logic dmemREN, dmemWEN, dhit,
  input  logic imemREN, ihit,
  input  logic [cachePkg::WORD_W-1:0] dmemAddr, dmemStore, dmemLoad,
  input  logic [cachePkg::WORD_W-1:0] imemAddr, imemLoad,
  output int errors, checks
);
  import cachePkg::*;

  logic [WORD_W-1:0] shadow [1024];   // loaded by the testbench at time 0

  // word the datapath should see at addr
  function automatic logic [WORD_W-1:0] expectedWord(input logic [WORD_W-1:0] addr);
    return shadow[addr[11:2]];
  endfunction

  always @(posedge CLK or negedge nRST) begin
    int e;
    int c;
    e = 0;
    c = 0;
    if (!nRST) begin
      errors <= 0;
      checks <= 0;
    end else begin
      if (dmemREN && dhit) begin
        c++;
        if (dmemLoad !== expectedWord(dmemAddr)) begin
          e++;
          $display("CHECK FAILED at %0t: data read %08h got %08h expected %08h",
                   $time, dmemAddr, dmemLoad, expectedWord(dmemAddr));
        end
      end
      if (imemREN && ihit) begin
        c++;
        if (imemLoad !== expectedWord(imemAddr)) begin
          e++;
          $display("CHECK FAILED at %0t: fetch %08h got %08h expected %08h",
                   $time, imemAddr, imemLoad, expectedWord(imemAddr));
        end
      end
      if (dmemWEN && dhit)
        shadow[dmemAddr[11:2]] <= dmemStore;   // store lands this edge
      errors <= errors + e;
      checks <= checks + c;
    end
  end

endmodule

`default_nettype wire

/* testbench/cacheSystem_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheSystem_chk (
  input logic CLK, nRST,
  input logic ramREN, ramWEN, ramWait, halt,
  input logic [cachePkg::WORD_W-1:0] ramAddr
);
  int assertFails = 0;   // read by the testbench summary

  noReadWrite: assert property (@(posedge CLK) disable iff (!nRST)
    !(ramREN && ramWEN))
    else begin
      $error("ramREN and ramWEN high in the same cycle");
      assertFails++;
    end

  // owner holds its address until the word moves
  addrStable: assert property (@(posedge CLK) disable iff (!nRST)
    (ramREN || ramWEN) && ramWait |=> $stable(ramAddr))
    else begin
      $error("ramAddr changed while ramWait was high");
      assertFails++;
    end

  haltSticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else begin
      $error("halt dropped before reset");
      assertFails++;
    end

endmodule

bind cacheSystem cacheSystem_chk u_chk (
  .CLK, .nRST, .ramREN, .ramWEN, .ramWait, .halt, .ramAddr
);

`default_nettype wire

/* testbench/tb_cacheSystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cacheSystem;
  import cachePkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_REQ    = 231;   // directed + 200 random + 16 flush frames

  logic CLK, nRST;
  logic dmemREN, dmemWEN, flush, imemREN;
  logic [WORD_W-1:0] dmemAddr, dmemStore, imemAddr;
  logic dhit, halt, ihit;
  logic [WORD_W-1:0] dmemLoad, imemLoad;
  logic ramREN, ramWEN, ramWait;
  logic [WORD_W-1:0] ramAddr, ramStore, ramLoad;

  logic [WORD_W-1:0] mem [1024];
  logic memPhase;   // second cycle of an access
  int tbErrors = 0;
  int monErrors, monChecks;
  int passCount = 0;
  int failCount = 0;

  cacheSystem u_dut (.*);

  cacheMonitor u_mon (
    .CLK, .nRST, .dmemREN, .dmemWEN, .dhit, .imemREN, .ihit, .dmemAddr,
    .dmemStore, .dmemLoad, .imemAddr, .imemLoad,
    .errors(monErrors), .checks(monChecks)
  );

  // two cycle memory
  assign ramWait = ~memPhase;
  assign ramLoad = mem[ramAddr[11:2]];

  always @(posedge CLK or negedge nRST) begin
    if (!nRST)
      memPhase <= 1'b0;
    else
      memPhase <= (ramREN | ramWEN) & ~memPhase;
  end

  always @(posedge CLK) begin
    if (ramWEN && memPhase)
      mem[ramAddr[11:2]] <= ramStore;
  end

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(NUM_REQ * 40 * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", NUM_REQ * 40);
    $display("TEST FAIL");
    $finish;
  end

  function automatic int totalErrors();
    return tbErrors + monErrors + u_dut.u_chk.assertFails;
  endfunction

  task automatic dataAccess(input logic wr, input logic [WORD_W-1:0] addr, wdata,
                            output int cycles, output logic busSeen);
    cycles  = 0;
    busSeen = 1'b0;
    @(posedge CLK);
    dmemREN   <= ~wr;
    dmemWEN   <= wr;
    dmemAddr  <= addr;
    dmemStore <= wdata;
    do begin
      @(posedge CLK);
      cycles++;
      busSeen |= ramREN | ramWEN;
    end while (!dhit);
    dmemREN <= 1'b0;
    dmemWEN <= 1'b0;
  endtask

  task automatic fetch(input logic [WORD_W-1:0] addr);
    @(posedge CLK);
    imemREN  <= 1'b1;
    imemAddr <= addr;
    do @(posedge CLK); while (!ihit);
    imemREN <= 1'b0;
  endtask

  task automatic finishTest(input string name, input int errBefore);
    @(negedge CLK);   // monitor counts settle
    if (totalErrors() == errBefore) begin
      passCount++;
      $display("test %s: ok", name);
    end else begin
      failCount++;
      $display("test %s: failed", name);
    end
  endtask

  initial begin
    int cyc;
    int kind;
    int base;
    logic bus;
    logic [WORD_W-1:0] addr, val;
    void'($urandom(49));
    nRST      <= 1'b0;
    dmemREN   <= 1'b0;
    dmemWEN   <= 1'b0;
    flush     <= 1'b0;
    imemREN   <= 1'b0;
    dmemAddr  <= '0;
    dmemStore <= '0;
    imemAddr  <= '0;
    for (int i = 0; i < 1024; i++) begin
      val = $urandom;
      mem[i] <= val;
      u_mon.shadow[i] <= val;
    end
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;

    base = totalErrors();
    dataAccess(1'b0, 32'h010, '0, cyc, bus);
    dataAccess(1'b0, 32'h014, '0, cyc, bus);
    if (cyc != 1 || bus) begin
      tbErrors++;
      $display("CHECK FAILED at %0t: second word took %0d cycles, bus used %0b",
               $time, cyc, bus);
    end
    finishTest("read miss then block hit", base);

    base = totalErrors();
    dataAccess(1'b1, 32'h020, 32'hA5A5_1234, cyc, bus);
    dataAccess(1'b0, 32'h020, '0, cyc, bus);
    finishTest("write then read", base);

    // 0x040 and 0x0C0 share index 8
    base = totalErrors();
    val = 32'hC0DE_0040;
    dataAccess(1'b1, 32'h040, val, cyc, bus);
    dataAccess(1'b0, 32'h0C0, '0, cyc, bus);
    if (mem[16] !== val) begin
      tbErrors++;
      $display("CHECK FAILED at %0t: write-back of 040 left %08h in memory",
               $time, mem[16]);
    end
    dataAccess(1'b0, 32'h040, '0, cyc, bus);
    finishTest("conflict eviction", base);

    base = totalErrors();
    fork
      for (int k = 0; k < 4; k++)
        dataAccess(1'b0, 32'h100 + k * 64, '0, cyc, bus);
      for (int k = 0; k < 4; k++)
        fetch(32'h800 + k * 4);
    join
    finishTest("fetch alongside data misses", base);

    // fetches stay above 0x800, where no store goes
    base = totalErrors();
    for (int n = 0; n < 200; n++) begin
      kind = $urandom % 3;
      addr = ($urandom % 128) << 2;
      val  = $urandom;
      if (kind == 2)
        fetch(32'h800 + (addr & 32'hFC));
      else
        dataAccess(kind == 1, addr, val, cyc, bus);
    end
    finishTest("random mix", base);

    base = totalErrors();
    @(posedge CLK);
    flush <= 1'b1;
    do @(posedge CLK); while (!halt);
    @(negedge CLK);
    for (int i = 0; i < 1024; i++) begin
      addr = i * 4;
      if (mem[i] !== u_mon.expectedWord(addr)) begin
        tbErrors++;
        $display("CHECK FAILED at %0t: memory %08h holds %08h after flush, expected %08h",
                 $time, addr, mem[i], u_mon.expectedWord(addr));
      end
    end
    finishTest("flush", base);

    $display("tests passed %0d failed %0d, %0d hit checks, %0d errors",
             passCount, failCount, monChecks, totalErrors());
    if (failCount == 0 && totalErrors() == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
design/cachePkg.sv
design/dcacheCtrl.sv
design/dcacheData.sv
design/icache.sv
design/memArbiter.sv
design/cacheSystem.sv
testbench/cacheSystem_chk.sv
testbench/cacheMonitor.sv
testbench/tb_cacheSystem.sv
